// ==== vlog.f ====
+incdir+testbench
verilog/harness_pkg.sv
verilog/lane_if.sv
verilog/harness_input_register.sv
verilog/accumulator_lane.sv
verilog/harness_output_register.sv
verilog/harness_top.sv
testbench/tb_harness_top.sv

// ==== testbench/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// --------------------
// Random bits

logic [31:0] lfsr_state = 32'hf476;

// Galois LFSR stepped once per bit taken
function automatic logic next_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
        lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    return out;
endfunction

function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        r = {r[30:0], next_bit()};
    end
    return r;
endfunction

// --------------------
// Reference lanes

logic [harness_pkg::WORD_W-1:0] model_acc [harness_pkg::LANE_COUNT];

function automatic logic [harness_pkg::WORD_W-1:0] lane_result(
    input logic [harness_pkg::WORD_W-1:0] acc,
    input logic [harness_pkg::OP_W-1:0]   op,
    input logic [harness_pkg::WORD_W-1:0] operand
);
    int modulus;
    int value;
    modulus = 1 << harness_pkg::WORD_W;
    case (op)
        harness_pkg::OP_ADD: value = (int'(acc) + int'(operand)) % modulus;
        harness_pkg::OP_SUB: value = (int'(acc) - int'(operand) + modulus) % modulus;
        harness_pkg::OP_XOR: value = int'(acc ^ operand);
        default:             value = int'(operand);
    endcase
    return harness_pkg::WORD_W'(value);
endfunction

// --------------------
// Compare tasks

task automatic check_acc(
    input int                             lane,
    input logic [harness_pkg::WORD_W-1:0] got,
    input logic [harness_pkg::WORD_W-1:0] exp
);
    if (got !== exp) begin
        value_errors++;
        $display("FAIL %0t: lane %0d accumulator %02h, expected %02h", $time, lane, got, exp);
    end
endtask

task automatic check_zero(input int lane, input logic got, input logic exp);
    if (got !== exp) begin
        value_errors++;
        $display("FAIL %0t: lane %0d zero flag %b, expected %b", $time, lane, got, exp);
    end
endtask

task automatic check_cycles(input string what, input int got, input int exp);
    if (got != exp) begin
        value_errors++;
        $display("FAIL %0t: %s is %0d cycles, expected %0d", $time, what, got, exp);
    end
endtask

`endif

// ==== testbench/tb_harness_top.sv ====
`timescale 1ns/1ps

module tb_harness_top;

    // Edges from the last input sample to the first output sample
    localparam int LATENCY    = 3;
    localparam int WAIT_LIMIT = 100;

    logic clock;
    logic arst_n;
    logic test_in;
    logic test_in_en;
    logic test_out;
    logic test_out_valid;

    int value_errors;
    int timeout_errors;

    // Commands for the next frame
    logic                           cmd_valid   [harness_pkg::LANE_COUNT];
    logic [harness_pkg::OP_W-1:0]   cmd_op      [harness_pkg::LANE_COUNT];
    logic [harness_pkg::WORD_W-1:0] cmd_operand [harness_pkg::LANE_COUNT];

    `include "tb_model.svh"

    harness_top i_dut (
        .clock          (clock),
        .arst_n         (arst_n),
        .test_in        (test_in),
        .test_in_en     (test_in_en),
        .test_out       (test_out),
        .test_out_valid (test_out_valid)
    );

    always #20 clock = ~clock;

// --------------------
// Serial drive and capture

    task automatic next_cycle();
        @(posedge clock);
        #2;
    endtask

    // Idle cycles carry junk on test_in
    task automatic drive_idle(input int n);
        for (int i = 0; i < n; i++) begin
            test_in_en = 1'b0;
            test_in    = next_bit();
            next_cycle();
        end
    endtask

    task automatic send_frame(input logic [harness_pkg::FRAME_IN_W-1:0] frame, input bit gaps);
        for (int i = harness_pkg::FRAME_IN_W - 1; i >= 0; i--) begin
            if (gaps) begin
                drive_idle(int'(rand_bits(2)));
            end
            test_in    = frame[i];
            test_in_en = 1'b1;
            next_cycle();
        end
        test_in_en = 1'b0;
        test_in    = 1'b0;
    endtask

    task automatic capture_result(output logic [harness_pkg::FRAME_OUT_W-1:0] res);
        int waited;
        int count;
        res    = '0;
        waited = 0;
        while (!test_out_valid && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (!test_out_valid) begin
            timeout_errors++;
            $display("Timeout: test_out_valid never went high after the input frame");
        end else begin
            // First valid bit is sampled on the following edge
            check_cycles("output latency", waited + 1, LATENCY);
            count = 0;
            while (test_out_valid && count < WAIT_LIMIT) begin
                res = {res[harness_pkg::FRAME_OUT_W-2:0], test_out};
                count++;
                next_cycle();
            end
            if (test_out_valid) begin
                timeout_errors++;
                $display("Timeout: test_out_valid stayed high and never dropped");
            end else begin
                check_cycles("output valid window", count, harness_pkg::FRAME_OUT_W);
            end
        end
    endtask

// --------------------
// Frames

    task automatic run_frame(input bit gaps);
        logic [harness_pkg::FRAME_IN_W-1:0]  frame;
        logic [harness_pkg::FRAME_OUT_W-1:0] res;
        logic [harness_pkg::WORD_W-1:0]      got_acc;
        logic                                got_zero;
        for (int l = 0; l < harness_pkg::LANE_COUNT; l++) begin
            frame[l * harness_pkg::CMD_W +: harness_pkg::CMD_W] =
                {cmd_valid[l], cmd_op[l], cmd_operand[l]};
            if (cmd_valid[l]) begin
                model_acc[l] = lane_result(model_acc[l], cmd_op[l], cmd_operand[l]);
            end
        end
        send_frame(frame, gaps);
        capture_result(res);
        for (int l = 0; l < harness_pkg::LANE_COUNT; l++) begin
            got_zero = res[l * harness_pkg::RES_W + harness_pkg::WORD_W];
            got_acc  = res[l * harness_pkg::RES_W +: harness_pkg::WORD_W];
            check_acc(l, got_acc, model_acc[l]);
            check_zero(l, got_zero, model_acc[l] == '0);
        end
    endtask

    task automatic set_lane(input int l, input logic valid, input logic [1:0] op);
        cmd_valid[l]   = valid;
        cmd_op[l]      = op;
        cmd_operand[l] = harness_pkg::WORD_W'(rand_bits(harness_pkg::WORD_W));
    endtask

    task automatic randomize_cmds();
        for (int l = 0; l < harness_pkg::LANE_COUNT; l++) begin
            set_lane(l, next_bit(), harness_pkg::OP_W'(rand_bits(harness_pkg::OP_W)));
        end
    endtask

    task automatic finish_run();
        $display("Summary: %0d value errors, %0d timeouts", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    endtask

// --------------------
// Sequence

    initial begin
        clock          = 1'b0;
        arst_n         = 1'b0;
        test_in        = 1'b0;
        test_in_en     = 1'b0;
        value_errors   = 0;
        timeout_errors = 0;
        for (int l = 0; l < harness_pkg::LANE_COUNT; l++) begin
            model_acc[l] = '0;
        end
        repeat (3) @(posedge clock);
        #2;
        arst_n = 1'b1;

        // Nothing valid so the reset state comes back
        for (int l = 0; l < harness_pkg::LANE_COUNT; l++) begin
            set_lane(l, 1'b0, harness_pkg::OP_W'(rand_bits(harness_pkg::OP_W)));
        end
        run_frame(1'b0);

        // LOAD everywhere with a zero operand on lane 1
        for (int l = 0; l < harness_pkg::LANE_COUNT; l++) begin
            set_lane(l, 1'b1, harness_pkg::OP_LOAD);
        end
        cmd_operand[1] = '0;
        run_frame(1'b0);

        // Lane 2 invalid while the rest add
        for (int l = 0; l < harness_pkg::LANE_COUNT; l++) begin
            set_lane(l, l != 2, harness_pkg::OP_ADD);
        end
        run_frame(1'b0);

        // Idle gaps inside the frame
        for (int l = 0; l < harness_pkg::LANE_COUNT; l++) begin
            set_lane(l, 1'b1, harness_pkg::OP_XOR);
        end
        run_frame(1'b1);

        for (int f = 0; f < 200; f++) begin
            randomize_cmds();
            run_frame(f % 8 == 7);
        end

        finish_run();
    end

endmodule

// ==== verilog/harness_top.sv ====
`timescale 1ns/1ps

module harness_top (
    input  logic clock,
    input  logic arst_n,
    input  logic test_in,
    input  logic test_in_en,
    output logic test_out,
    output logic test_out_valid
);

    lane_if lanes [harness_pkg::LANE_COUNT] ();

// --------------------
// Serial in

    harness_input_register i_in (
        .clock      (clock),
        .arst_n     (arst_n),
        .test_in    (test_in),
        .test_in_en (test_in_en),
        .lanes      (lanes)
    );

// --------------------
// Lanes

    for (genvar g = 0; g < harness_pkg::LANE_COUNT; g++) begin : g_lane
        accumulator_lane i_lane (
            .clock  (clock),
            .arst_n (arst_n),
            .port   (lanes[g])
        );
    end

// --------------------
// Serial out

    harness_output_register i_out (
        .clock          (clock),
        .arst_n         (arst_n),
        .lanes          (lanes),
        .test_out       (test_out),
        .test_out_valid (test_out_valid)
    );

endmodule

// ==== verilog/harness_output_register.sv ====
`timescale 1ns/1ps

module harness_output_register (
    input  logic  clock,
    input  logic  arst_n,
    lane_if.drain lanes [harness_pkg::LANE_COUNT],
    output logic  test_out,
    output logic  test_out_valid
);

    logic [harness_pkg::FRAME_OUT_W-1:0] res_frame;
    logic [harness_pkg::FRAME_OUT_W-1:0] shift_q;
    logic [harness_pkg::LANE_COUNT-1:0]  done_vec;
    logic [harness_pkg::OUT_CNT_W-1:0]   bit_cnt;

// --------------------
// Gather lane results

    for (genvar g = 0; g < harness_pkg::LANE_COUNT; g++) begin : g_drain
        assign res_frame[g * harness_pkg::RES_W +: harness_pkg::RES_W] =
            {lanes[g].zero, lanes[g].acc};
        assign done_vec[g] = lanes[g].done;
    end

// --------------------
// Shift out MSB first

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            test_out_valid <= 1'b0;
            bit_cnt        <= '0;
        end else if (done_vec[0]) begin
            test_out_valid <= 1'b1;
            bit_cnt        <= harness_pkg::OUT_LAST;
        end else if (test_out_valid) begin
            if (bit_cnt == '0) begin
                test_out_valid <= 1'b0;
            end else begin
                bit_cnt <= bit_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (done_vec[0]) begin
            shift_q <= res_frame;
        end else if (test_out_valid) begin
            shift_q <= {shift_q[harness_pkg::FRAME_OUT_W-2:0], 1'b0};
        end
    end

    assign test_out = shift_q[harness_pkg::FRAME_OUT_W-1];

// --------------------
// Checks

    // No back-pressure, so a new result must not land mid-shift
    a_no_overlap: assert property (
        @(posedge clock) disable iff (!arst_n)
        (|done_vec) |-> !test_out_valid
    );

    // All lanes finish together
    a_done_aligned: assert property (
        @(posedge clock) disable iff (!arst_n)
        (|done_vec) |-> (&done_vec)
    );

endmodule

// ==== verilog/accumulator_lane.sv ====
`timescale 1ns/1ps

module accumulator_lane (
    input  logic clock,
    input  logic arst_n,
    lane_if.lane port
);

    logic [harness_pkg::WORD_W-1:0] acc_next;

// --------------------
// Opcode execution

    always_comb begin
        case (port.op)
            harness_pkg::OP_ADD:  acc_next = port.acc + port.operand;
            harness_pkg::OP_SUB:  acc_next = port.acc - port.operand;
            harness_pkg::OP_XOR:  acc_next = port.acc ^ port.operand;
            harness_pkg::OP_LOAD: acc_next = port.operand;
            default:              acc_next = port.acc;
        endcase
    end

    // Invalid command still reports done but holds acc
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            port.acc  <= '0;
            port.zero <= 1'b1;
            port.done <= 1'b0;
        end else begin
            port.done <= port.strobe;
            if (port.strobe && port.cmd_valid) begin
                port.acc  <= acc_next;
                port.zero <= (acc_next == '0);
            end
        end
    end

// --------------------
// Checks

    // Each command arrives as a one-cycle strobe
    a_strobe_pulse: assert property (
        @(posedge clock) disable iff (!arst_n)
        port.strobe |=> !port.strobe
    );

endmodule

// ==== verilog/harness_input_register.sv ====
`timescale 1ns/1ps

module harness_input_register (
    input  logic clock,
    input  logic arst_n,
    input  logic test_in,
    input  logic test_in_en,
    lane_if.feed lanes [harness_pkg::LANE_COUNT]
);

    logic [harness_pkg::FRAME_IN_W-1:0] shift_q;
    logic [harness_pkg::FRAME_IN_W-1:0] shift_next;
    logic [harness_pkg::FRAME_IN_W-1:0] cmd_q;
    logic [harness_pkg::IN_CNT_W-1:0]   bit_cnt;
    logic                               strobe_q;
    logic                               frame_done;

// --------------------
// Serial capture

    assign shift_next = {shift_q[harness_pkg::FRAME_IN_W-2:0], test_in};
    assign frame_done = test_in_en && (bit_cnt == harness_pkg::IN_LAST);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            bit_cnt  <= '0;
            strobe_q <= 1'b0;
        end else begin
            strobe_q <= frame_done;
            if (frame_done) begin
                bit_cnt <= '0;
            end else if (test_in_en) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (test_in_en) begin
            shift_q <= shift_next;
        end
        // Whole frame lands with the last bit
        if (frame_done) begin
            cmd_q <= shift_next;
        end
    end

// --------------------
// Per-lane slicing

    for (genvar g = 0; g < harness_pkg::LANE_COUNT; g++) begin : g_feed
        localparam int BASE = g * harness_pkg::CMD_W;

        // Lane 3 arrives first and sits in the top bits
        assign lanes[g].strobe    = strobe_q;
        assign lanes[g].cmd_valid = cmd_q[BASE + harness_pkg::CMD_W - 1];
        assign lanes[g].op        = cmd_q[BASE + harness_pkg::WORD_W +: harness_pkg::OP_W];
        assign lanes[g].operand   = cmd_q[BASE +: harness_pkg::WORD_W];
    end

// --------------------
// Checks

    // Counter never runs past the last frame bit
    a_cnt_range: assert property (
        @(posedge clock) disable iff (!arst_n)
        bit_cnt <= harness_pkg::IN_LAST
    );

endmodule

// ==== verilog/lane_if.sv ====
`timescale 1ns/1ps

interface lane_if;

    // Command side
    logic                            strobe;
    logic                            cmd_valid;
    logic [harness_pkg::OP_W-1:0]    op;
    logic [harness_pkg::WORD_W-1:0]  operand;

    // Result side
    logic [harness_pkg::WORD_W-1:0]  acc;
    logic                            zero;
    logic                            done;

    modport feed (
        output strobe,
        output cmd_valid,
        output op,
        output operand
    );

    modport lane (
        input  strobe,
        input  cmd_valid,
        input  op,
        input  operand,
        output acc,
        output zero,
        output done
    );

    modport drain (
        input  acc,
        input  zero,
        input  done
    );

endinterface

// ==== verilog/harness_pkg.sv ====
package harness_pkg;

    // Lane geometry
    localparam int LANE_COUNT = 4;
    localparam int WORD_W     = 8;
    localparam int OP_W       = 2;

    // Per-lane command is valid, opcode, operand
    localparam int CMD_W = 1 + OP_W + WORD_W;
    // Per-lane result is zero flag, accumulator
    localparam int RES_W = 1 + WORD_W;

    localparam int FRAME_IN_W  = LANE_COUNT * CMD_W;
    localparam int FRAME_OUT_W = LANE_COUNT * RES_W;

    // Serial bit counters
    localparam int IN_CNT_W  = $clog2(FRAME_IN_W);
    localparam int OUT_CNT_W = $clog2(FRAME_OUT_W);
    localparam logic [IN_CNT_W-1:0]  IN_LAST  = IN_CNT_W'(FRAME_IN_W - 1);
    localparam logic [OUT_CNT_W-1:0] OUT_LAST = OUT_CNT_W'(FRAME_OUT_W - 1);

    // Opcodes
    localparam logic [OP_W-1:0] OP_ADD  = 2'd0;
    localparam logic [OP_W-1:0] OP_SUB  = 2'd1;
    localparam logic [OP_W-1:0] OP_XOR  = 2'd2;
    localparam logic [OP_W-1:0] OP_LOAD = 2'd3;

endpackage
